//--- design/prf_pkg.sv
package prf_pkg;

	//////////////////////////////////////////////////
	// sizes of the physical register file
	//////////////////////////////////////////////////

	localparam int PRF_SIZE   = 64;                  // physical registers for the one rename thread
	localparam int PRF_IDX_W  = $clog2(PRF_SIZE);    // 6 bits of entry index
	localparam int PRF_DATA_W = 64;                  // width of a register value

	//////////////////////////////////////////////////
	// shared types
	//////////////////////////////////////////////////

	// index of one physical register, as carried on rename, CDB and retire
	typedef logic [PRF_IDX_W-1:0] prf_idx_t;

	// one register value, also the width of every read port
	typedef logic [PRF_DATA_W-1:0] prf_data_t;

	// one bit per entry, used for free, ready, grant and release vectors
	typedef logic [PRF_SIZE-1:0] prf_mask_t;

	// life cycle of an entry
	// free goes to pending on a grant, pending goes to ready on a CDB write,
	// and either of them goes back to free on a retire release or a mispredict
	typedef enum logic [1:0]
	{
		PRF_FREE    = 2'b00,  // sitting in the free pool
		PRF_PENDING = 2'b01,  // handed to rename, value still in flight
		PRF_READY   = 2'b10   // value has been written by a CDB port
	} prf_state_e;

	// the encoding 2'b11 is never produced by the entry array

endpackage

//--- design/prf_alloc.sv
module prf_alloc
	import prf_pkg::*;
(
	input  logic      alloc_req1,    // rename asks for a first new entry
	input  logic      alloc_req2,    // rename asks for a second new entry
	input  prf_mask_t free_mask,     // entries currently in the free pool

	output logic      alloc_valid1,  // slot 1 got an entry this cycle
	output logic      alloc_valid2,  // slot 2 got an entry this cycle
	output prf_idx_t  alloc_idx1,    // entry granted to slot 1, zero when not valid
	output prf_idx_t  alloc_idx2,    // entry granted to slot 2, zero when not valid
	output prf_mask_t grant_mask,    // both grants merged, goes to the entry array
	output logic      prf_full       // no entry left in the free pool
);

	//////////////////////////////////////////////////
	// lowest-index search
	//////////////////////////////////////////////////

	// returns the lowest set bit of the mask as an index
	// an empty mask returns zero, so the caller has to qualify with an or-reduce
	function automatic prf_idx_t lowest_free(input prf_mask_t mask);
		prf_idx_t idx;
		idx = '0;
		for (int i = PRF_SIZE - 1; i >= 0; i--)
		begin
			if (mask[i])
			begin
				idx = prf_idx_t'(i);  // later hits are lower indices and overwrite
			end
		end
		return idx;
	endfunction

	prf_mask_t search2_mask;   // free entries left over for slot 2
	prf_mask_t slot1_onehot;   // slot 1 grant as a one-hot vector
	prf_mask_t slot2_onehot;   // slot 2 grant as a one-hot vector

	//////////////////////////////////////////////////
	// slot 1 searches the whole free pool
	//////////////////////////////////////////////////

	assign alloc_valid1 = alloc_req1 && (|free_mask);
	assign alloc_idx1   = alloc_valid1 ? lowest_free(free_mask) : '0;
	assign slot1_onehot = alloc_valid1 ? (prf_mask_t'(1) << alloc_idx1) : '0;

	//////////////////////////////////////////////////
	// slot 2 searches what slot 1 left behind
	//////////////////////////////////////////////////

	// when slot 1 was not granted its one-hot is zero, so slot 2 sees the full pool
	assign search2_mask = free_mask & ~slot1_onehot;

	assign alloc_valid2 = alloc_req2 && (|search2_mask);
	assign alloc_idx2   = alloc_valid2 ? lowest_free(search2_mask) : '0;
	assign slot2_onehot = alloc_valid2 ? (prf_mask_t'(1) << alloc_idx2) : '0;

	// the array marks these entries pending at the next edge
	assign grant_mask = slot1_onehot | slot2_onehot;

	// full means nothing free at all, independent of the requests
	assign prf_full = ~(|free_mask);

endmodule

//--- design/prf_release.sv
module prf_release
	import prf_pkg::*;
(
	input  logic      rel1_valid,            // first retire release this cycle
	input  prf_idx_t  rel1_idx,              // entry freed by the first retire
	input  logic      rel2_valid,            // second retire release this cycle
	input  prf_idx_t  rel2_idx,              // entry freed by the second retire
	input  logic      mispredict_valid,      // branch mispredict, drop the speculative entries
	input  prf_mask_t mispredict_free_list,  // entries to free on a mispredict

	output prf_mask_t release_mask           // entries that go back to the free pool
);

	prf_mask_t retire_mask;  // decoded retire releases

	// decode the two retire indices into one mask
	always_comb
	begin
		retire_mask = '0;
		if (rel1_valid)
		begin
			retire_mask[rel1_idx] = 1'b1;
		end
		if (rel2_valid)
		begin
			retire_mask[rel2_idx] = 1'b1;
		end
	end

	// a mispredict replaces the retire releases of the same cycle,
	// its list already covers everything that has to leave
	assign release_mask = mispredict_valid ? mispredict_free_list : retire_mask;

	//////////////////////////////////////////////////
	// retire port check
	//////////////////////////////////////////////////

	// both retire ports naming one entry would mean the retirement table
	// mapped one physical register to two architectural ones
	always_comb
	begin
		if (rel1_valid && rel2_valid && !mispredict_valid)
		begin
			a_rel_idx_differ : assert final (rel1_idx != rel2_idx)
				else $error("retire releases both name entry %0d", rel1_idx);
		end
	end

endmodule

//--- design/prf_entry_array.sv
module prf_entry_array
	import prf_pkg::*;
(
	input  logic      clock,
	input  logic      rst_n,

	input  prf_mask_t grant_mask,    // entries handed to rename this cycle
	input  prf_mask_t release_mask,  // entries going back to the free pool

	input  logic      cdb1_valid,    // first result bus carries a value
	input  prf_idx_t  cdb1_tag,      // destination entry of the first bus
	input  prf_data_t cdb1_data,     // value on the first bus
	input  logic      cdb2_valid,    // second result bus carries a value
	input  prf_idx_t  cdb2_tag,      // destination entry of the second bus
	input  prf_data_t cdb2_data,     // value on the second bus

	output prf_mask_t free_mask,     // one bit per entry in state free
	output prf_mask_t ready_mask,    // one bit per entry in state ready
	output prf_data_t entry_data [PRF_SIZE]  // stored value of every entry
);

	prf_state_e entry_state [PRF_SIZE];  // where each entry is in its life cycle
	prf_data_t  entry_value [PRF_SIZE];  // payload of each entry

	prf_mask_t  cdb_hit;                 // entries written by either bus this cycle
	prf_data_t  cdb_value [PRF_SIZE];    // value that each hit entry takes

	//////////////////////////////////////////////////
	// CDB decode
	//////////////////////////////////////////////////

	always_comb
	begin
		for (int i = 0; i < PRF_SIZE; i++)
		begin
			cdb_hit[i]   = 1'b0;
			cdb_value[i] = cdb1_data;
			if (cdb1_valid && (cdb1_tag == prf_idx_t'(i)))
			begin
				cdb_hit[i] = 1'b1;
			end
			if (cdb2_valid && (cdb2_tag == prf_idx_t'(i)))
			begin
				cdb_hit[i]   = 1'b1;
				cdb_value[i] = cdb2_data;  // the two tags never match, so no real overlap
			end
		end
	end

	//////////////////////////////////////////////////
	// state and data update
	//////////////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		for (int i = 0; i < PRF_SIZE; i++)
		begin
			if (!rst_n)
			begin
				entry_state[i] <= PRF_FREE;
				entry_value[i] <= '0;
			end
			else if (release_mask[i])
			begin
				entry_state[i] <= PRF_FREE;  // release beats a late CDB write
			end
			else if (grant_mask[i])
			begin
				entry_state[i] <= PRF_PENDING;
			end
			else if (cdb_hit[i])
			begin
				entry_state[i] <= PRF_READY;
				entry_value[i] <= cdb_value[i];
			end
		end
	end

	// status vectors for the allocator and the read ports
	always_comb
	begin
		for (int i = 0; i < PRF_SIZE; i++)
		begin
			free_mask[i]  = (entry_state[i] == PRF_FREE);
			ready_mask[i] = (entry_state[i] == PRF_READY);
			entry_data[i] = entry_value[i];
		end
	end

	//////////////////////////////////////////////////
	// protocol checks
	//////////////////////////////////////////////////

	// the two result buses come from different functional units, never the same tag
	a_cdb_tags_differ : assert property (@(posedge clock) disable iff (!rst_n)
		(cdb1_valid && cdb2_valid) |-> (cdb1_tag != cdb2_tag));

	// a result only lands on an entry that rename handed out and is still waiting
	a_cdb1_pending : assert property (@(posedge clock) disable iff (!rst_n)
		cdb1_valid |-> (entry_state[cdb1_tag] == PRF_PENDING));
	a_cdb2_pending : assert property (@(posedge clock) disable iff (!rst_n)
		cdb2_valid |-> (entry_state[cdb2_tag] == PRF_PENDING));

	// grants come out of the free pool and releases name allocated entries
	a_grant_release_disjoint : assert property (@(posedge clock) disable iff (!rst_n)
		(grant_mask & release_mask) == '0);

endmodule

//--- design/prf_read.sv
module prf_read
	import prf_pkg::*;
(
	input  prf_mask_t ready_mask,             // entries holding a written value
	input  prf_data_t entry_data [PRF_SIZE],  // stored value of every entry

	input  prf_idx_t  inst1_opa_idx,          // operand a of the first instruction
	input  prf_idx_t  inst1_opb_idx,          // operand b of the first instruction
	input  prf_idx_t  inst2_opa_idx,          // operand a of the second instruction
	input  prf_idx_t  inst2_opb_idx,          // operand b of the second instruction
	input  prf_idx_t  retire_idx,             // entry of the retiring instruction

	output prf_data_t inst1_opa_value,
	output prf_data_t inst1_opb_value,
	output prf_data_t inst2_opa_value,
	output prf_data_t inst2_opb_value,
	output prf_data_t writeback_value,        // retire readout, zero when not ready

	output logic      inst1_opa_valid,        // value is real data, not a tag
	output logic      inst1_opb_valid,
	output logic      inst2_opa_valid,
	output logic      inst2_opb_valid
);

	localparam int NUM_OPS = 4;  // two operands for each of two instructions

	prf_idx_t  op_idx   [NUM_OPS];  // operand ports gathered so one loop serves all
	prf_data_t op_value [NUM_OPS];
	logic      op_valid [NUM_OPS];

	assign op_idx[0] = inst1_opa_idx;
	assign op_idx[1] = inst1_opb_idx;
	assign op_idx[2] = inst2_opa_idx;
	assign op_idx[3] = inst2_opb_idx;

	//////////////////////////////////////////////////
	// operand read ports
	//////////////////////////////////////////////////

	// a ready entry gives its value, otherwise the reservation station
	// gets the tag back so it can wait for that entry on the CDB
	always_comb
	begin
		for (int k = 0; k < NUM_OPS; k++)
		begin
			op_valid[k] = ready_mask[op_idx[k]];
			if (op_valid[k])
			begin
				op_value[k] = entry_data[op_idx[k]];
			end
			else
			begin
				op_value[k] = {{(PRF_DATA_W - PRF_IDX_W){1'b0}}, op_idx[k]};  // zero-extended tag
			end
		end
	end

	assign inst1_opa_value = op_value[0];
	assign inst1_opb_value = op_value[1];
	assign inst2_opa_value = op_value[2];
	assign inst2_opb_value = op_value[3];

	assign inst1_opa_valid = op_valid[0];
	assign inst1_opb_valid = op_valid[1];
	assign inst2_opa_valid = op_valid[2];
	assign inst2_opb_valid = op_valid[3];

	//////////////////////////////////////////////////
	// retire readout
	//////////////////////////////////////////////////

	// retire should only see ready entries, zero makes a stray read obvious
	assign writeback_value = ready_mask[retire_idx] ? entry_data[retire_idx] : '0;

endmodule

//--- design/prf_top.sv
module prf_top
	import prf_pkg::*;
(
	input  logic      clock,
	input  logic      rst_n,

	// rename allocation
	input  logic      alloc_req1,
	input  logic      alloc_req2,
	output logic      alloc_valid1,
	output logic      alloc_valid2,
	output prf_idx_t  alloc_idx1,
	output prf_idx_t  alloc_idx2,
	output logic      prf_full,

	// result buses
	input  logic      cdb1_valid,
	input  prf_idx_t  cdb1_tag,
	input  prf_data_t cdb1_data,
	input  logic      cdb2_valid,
	input  prf_idx_t  cdb2_tag,
	input  prf_data_t cdb2_data,

	// retire releases and mispredict recovery
	input  logic      rel1_valid,
	input  prf_idx_t  rel1_idx,
	input  logic      rel2_valid,
	input  prf_idx_t  rel2_idx,
	input  logic      mispredict_valid,
	input  prf_mask_t mispredict_free_list,

	// operand and retire reads
	input  prf_idx_t  inst1_opa_idx,
	input  prf_idx_t  inst1_opb_idx,
	input  prf_idx_t  inst2_opa_idx,
	input  prf_idx_t  inst2_opb_idx,
	input  prf_idx_t  retire_idx,
	output prf_data_t inst1_opa_value,
	output prf_data_t inst1_opb_value,
	output prf_data_t inst2_opa_value,
	output prf_data_t inst2_opb_value,
	output logic      inst1_opa_valid,
	output logic      inst1_opb_valid,
	output logic      inst2_opa_valid,
	output logic      inst2_opb_valid,
	output prf_data_t writeback_value
);

	prf_mask_t free_mask;                // entry array to allocator
	prf_mask_t ready_mask;               // entry array to read ports
	prf_mask_t grant_mask;               // allocator to entry array
	prf_mask_t release_mask;             // release decode to entry array
	prf_data_t entry_data [PRF_SIZE];    // entry array to read ports

	prf_alloc u_prf_alloc (
		.alloc_req1   (alloc_req1),
		.alloc_req2   (alloc_req2),
		.free_mask    (free_mask),
		.alloc_valid1 (alloc_valid1),
		.alloc_valid2 (alloc_valid2),
		.alloc_idx1   (alloc_idx1),
		.alloc_idx2   (alloc_idx2),
		.grant_mask   (grant_mask),
		.prf_full     (prf_full)
	);

	prf_release u_prf_release (
		.rel1_valid           (rel1_valid),
		.rel1_idx             (rel1_idx),
		.rel2_valid           (rel2_valid),
		.rel2_idx             (rel2_idx),
		.mispredict_valid     (mispredict_valid),
		.mispredict_free_list (mispredict_free_list),
		.release_mask         (release_mask)
	);

	prf_entry_array u_prf_entry_array (
		.clock        (clock),
		.rst_n        (rst_n),
		.grant_mask   (grant_mask),
		.release_mask (release_mask),
		.cdb1_valid   (cdb1_valid),
		.cdb1_tag     (cdb1_tag),
		.cdb1_data    (cdb1_data),
		.cdb2_valid   (cdb2_valid),
		.cdb2_tag     (cdb2_tag),
		.cdb2_data    (cdb2_data),
		.free_mask    (free_mask),
		.ready_mask   (ready_mask),
		.entry_data   (entry_data)
	);

	prf_read u_prf_read (
		.ready_mask      (ready_mask),
		.entry_data      (entry_data),
		.inst1_opa_idx   (inst1_opa_idx),
		.inst1_opb_idx   (inst1_opb_idx),
		.inst2_opa_idx   (inst2_opa_idx),
		.inst2_opb_idx   (inst2_opb_idx),
		.retire_idx      (retire_idx),
		.inst1_opa_value (inst1_opa_value),
		.inst1_opb_value (inst1_opb_value),
		.inst2_opa_value (inst2_opa_value),
		.inst2_opb_value (inst2_opb_value),
		.writeback_value (writeback_value),
		.inst1_opa_valid (inst1_opa_valid),
		.inst1_opb_valid (inst1_opb_valid),
		.inst2_opa_valid (inst2_opa_valid),
		.inst2_opb_valid (inst2_opb_valid)
	);

endmodule

//--- verif/prf_clock_gen.sv
module prf_clock_gen
(
	output logic clock
);

	// free-running testbench clock with a period of 8 time units
	initial
	begin
		clock = 1'b0;
	end

	always #4 clock = ~clock;  // half period

endmodule

//--- verif/prf_tb.sv
module prf_tb
	import prf_pkg::*;
();

	localparam int RESET_CYCLES   = 3;
	localparam int RANDOM_CYCLES  = 2000;
	localparam int STIM_CYCLES    = RESET_CYCLES + 100 + RANDOM_CYCLES;  // directed part is under 100
	localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES;

	// expected value of every DUT output in one cycle
	typedef struct packed
	{
		logic      valid1, valid2, full;
		prf_idx_t  idx1, idx2;
		prf_data_t opa1, opb1, opa2, opb2, wb;
		logic      va1, vb1, va2, vb2;
	} expect_t;

	logic      clock;
	logic      rst_n = 1'b0;
	logic      alloc_req1 = 1'b0, alloc_req2 = 1'b0;
	logic      cdb1_valid = 1'b0, cdb2_valid = 1'b0;
	prf_idx_t  cdb1_tag = '0, cdb2_tag = '0;
	prf_data_t cdb1_data = '0, cdb2_data = '0;
	logic      rel1_valid = 1'b0, rel2_valid = 1'b0, mispredict_valid = 1'b0;
	prf_idx_t  rel1_idx = '0, rel2_idx = '0;
	prf_mask_t mispredict_free_list = '0;
	prf_idx_t  inst1_opa_idx = '0, inst1_opb_idx = '0, inst2_opa_idx = '0, inst2_opb_idx = '0;
	prf_idx_t  retire_idx = '0;
	logic      alloc_valid1, alloc_valid2, prf_full;
	prf_idx_t  alloc_idx1, alloc_idx2;
	prf_data_t inst1_opa_value, inst1_opb_value, inst2_opa_value, inst2_opb_value;
	prf_data_t writeback_value;
	logic      inst1_opa_valid, inst1_opb_valid, inst2_opa_valid, inst2_opb_valid;

	prf_state_e m_state [PRF_SIZE];  // model of each entry's life cycle
	prf_data_t  m_data  [PRF_SIZE];  // model of each entry's value
	prf_mask_t  m_allocated;         // entries not in the free pool that a mispredict may name
	logic       checks_on   = 1'b0;
	int         cycle_count = 0;

	prf_clock_gen u_prf_clock_gen (.clock(clock));

	prf_top u_prf_top (.*);

	//////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////

	// a ready entry gives its value, anything else gives the tag back
	function automatic prf_data_t operand_value(input prf_idx_t idx);
		return (m_state[idx] == PRF_READY) ? m_data[idx] : prf_data_t'(idx);
	endfunction

	function automatic expect_t ref_outputs();
		expect_t e;
		e      = '0;
		e.full = 1'b1;
		for (int i = 0; i < PRF_SIZE; i++)
		begin
			if (m_state[i] == PRF_FREE)
			begin
				e.full = 1'b0;
				if (alloc_req1 && !e.valid1)
				begin
					e.valid1 = 1'b1;  // slot 1 takes the lowest free entry
					e.idx1   = prf_idx_t'(i);
				end
				else if (alloc_req2 && !e.valid2)
				begin
					e.valid2 = 1'b1;  // slot 2 takes the next one, or the lowest when slot 1 is idle
					e.idx2   = prf_idx_t'(i);
				end
			end
		end
		e.opa1 = operand_value(inst1_opa_idx);
		e.opb1 = operand_value(inst1_opb_idx);
		e.opa2 = operand_value(inst2_opa_idx);
		e.opb2 = operand_value(inst2_opb_idx);
		e.va1  = (m_state[inst1_opa_idx] == PRF_READY);
		e.vb1  = (m_state[inst1_opb_idx] == PRF_READY);
		e.va2  = (m_state[inst2_opa_idx] == PRF_READY);
		e.vb2  = (m_state[inst2_opb_idx] == PRF_READY);
		e.wb   = (m_state[retire_idx] == PRF_READY) ? m_data[retire_idx] : '0;
		return e;
	endfunction

	// one clock edge of the model where release goes before grant and grant before CDB write
	function automatic void model_edge();
		expect_t   e;
		prf_mask_t rel;
		e   = ref_outputs();
		rel = '0;
		if (mispredict_valid)
			rel = mispredict_free_list;  // retire releases of this cycle are dropped
		else
		begin
			if (rel1_valid)
				rel[rel1_idx] = 1'b1;
			if (rel2_valid)
				rel[rel2_idx] = 1'b1;
		end
		for (int i = 0; i < PRF_SIZE; i++)
		begin
			if (!rst_n)
			begin
				m_state[i] = PRF_FREE;
				m_data[i]  = '0;
			end
			else if (rel[i])
				m_state[i] = PRF_FREE;
			else if ((e.valid1 && e.idx1 == i) || (e.valid2 && e.idx2 == i))
				m_state[i] = PRF_PENDING;
			else if (cdb1_valid && cdb1_tag == i)
			begin
				m_state[i] = PRF_READY;
				m_data[i]  = cdb1_data;
			end
			else if (cdb2_valid && cdb2_tag == i)
			begin
				m_state[i] = PRF_READY;
				m_data[i]  = cdb2_data;
			end
			m_allocated[i] = (m_state[i] != PRF_FREE);
		end
	endfunction

	// picks a random pending entry or any allocated one but never the skipped index
	function automatic logic pick_entry(input logic pending_only, input logic skip_en,
		input prf_idx_t skip, output prf_idx_t idx);
		prf_idx_t pool [$];
		idx = '0;
		for (int i = 0; i < PRF_SIZE; i++)
		begin
			if ((m_state[i] == PRF_PENDING || (!pending_only && m_state[i] == PRF_READY))
				&& !(skip_en && skip == i))
				pool.push_back(prf_idx_t'(i));
		end
		if (pool.size() == 0)
			return 1'b0;
		idx = pool[$urandom % pool.size()];
		return 1'b1;
	endfunction

	//////////////////////////////////////////////////
	// checking
	//////////////////////////////////////////////////

	task automatic compare_value(input logic [63:0] got, input logic [63:0] expected,
		input string what);
		if (got !== expected)
		begin
			$display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, expected);
			$display("CHECKS FAILED");
			$fatal(1, "stopping at the first mismatch");
		end
	endtask

	// outputs are stable at the falling edge, half a period after the inputs moved
	always @(negedge clock)
	begin
		expect_t e;
		if (checks_on)
		begin
			e = ref_outputs();
			compare_value({alloc_valid1, alloc_valid2, alloc_idx1, alloc_idx2, prf_full},
				{e.valid1, e.valid2, e.idx1, e.idx2, e.full}, "allocation outputs");
			compare_value({inst1_opa_valid, inst1_opb_valid, inst2_opa_valid, inst2_opb_valid},
				{e.va1, e.vb1, e.va2, e.vb2}, "operand valid flags");
			compare_value(inst1_opa_value, e.opa1, "inst1_opa_value");
			compare_value(inst1_opb_value, e.opb1, "inst1_opb_value");
			compare_value(inst2_opa_value, e.opa2, "inst2_opa_value");
			compare_value(inst2_opb_value, e.opb2, "inst2_opb_value");
			compare_value(writeback_value, e.wb, "writeback_value");
		end
	end

	always @(posedge clock)
	begin
		cycle_count++;
		if (cycle_count > TIMEOUT_CYCLES)
		begin
			$display("timeout: the run went past %0d clock cycles", TIMEOUT_CYCLES);
			$display("CHECKS FAILED");
			$fatal(1, "run did not finish in time");
		end
	end

	//////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////

	task automatic step();
		@(posedge clock);
		model_edge();  // sees the inputs of the cycle that just ended
	endtask

	// next cycle with all strobes low except the two allocate requests
	task automatic request_cycle(input logic req1, input logic req2);
		step();
		alloc_req1       <= req1;
		alloc_req2       <= req2;
		cdb1_valid       <= 1'b0;
		cdb2_valid       <= 1'b0;
		rel1_valid       <= 1'b0;
		rel2_valid       <= 1'b0;
		mispredict_valid <= 1'b0;
	endtask

	initial
	begin
		prf_idx_t tag_a, tag_b;
		logic     got_a, got_b;
		void'($urandom(32'h3cfefaec));
		repeat (RESET_CYCLES) step();
		rst_n     <= 1'b1;
		checks_on = 1'b1;
		request_cycle(1'b1, 1'b1);  // first grants are 0 and 1
		@(negedge clock);
		compare_value(alloc_idx2, 64'd1, "slot 2 grant after reset");
		request_cycle(1'b0, 1'b1);
		repeat (31) request_cycle(1'b1, 1'b1);  // uses up the rest of the pool
		request_cycle(1'b1, 1'b1);
		@(negedge clock);
		compare_value(prf_full, 1'b1, "prf_full with every entry allocated");
		request_cycle(1'b0, 1'b0);
		rel1_valid <= 1'b1;
		rel1_idx   <= 6'd17;
		request_cycle(1'b1, 1'b0);
		@(negedge clock);
		compare_value(alloc_idx1, 64'd17, "grant of the released entry");
		request_cycle(1'b0, 1'b0);
		inst1_opa_idx <= 6'd5;
		inst1_opb_idx <= 6'd5;
		inst2_opa_idx <= 6'd6;
		inst2_opb_idx <= 6'd6;
		retire_idx    <= 6'd5;
		request_cycle(1'b0, 1'b0);  // results for the still pending entries 5 and 6
		cdb1_valid <= 1'b1;
		cdb1_tag   <= 6'd5;
		cdb1_data  <= 64'h0123_4567_89ab_cdef;
		cdb2_valid <= 1'b1;
		cdb2_tag   <= 6'd6;
		cdb2_data  <= 64'hfedc_ba98_7654_3210;
		request_cycle(1'b0, 1'b0);
		@(negedge clock);
		compare_value(writeback_value, 64'h0123_4567_89ab_cdef, "retire value after the write");
		request_cycle(1'b0, 1'b0);
		rel1_valid <= 1'b1;
		rel1_idx   <= 6'd5;
		rel2_valid <= 1'b1;
		rel2_idx   <= 6'd6;
		request_cycle(1'b1, 1'b1);
		request_cycle(1'b0, 1'b0);
		mispredict_valid     <= 1'b1;
		mispredict_free_list <= (prf_mask_t'(1) << 10) | (prf_mask_t'(1) << 20)
			| (prf_mask_t'(1) << 30);
		rel1_valid <= 1'b1;  // entry 40 has to stay allocated
		rel1_idx   <= 6'd40;
		repeat (3) request_cycle(1'b1, 1'b1);
		for (int n = 0; n < RANDOM_CYCLES; n++)
		begin
			request_cycle(1'($urandom % 2), 1'($urandom % 2));
			got_a = pick_entry(1'b1, 1'b0, '0, tag_a);
			if (got_a && ($urandom % 4 != 0))
			begin
				cdb1_valid <= 1'b1;
				cdb1_tag   <= tag_a;
				cdb1_data  <= {$urandom, $urandom};
			end
			got_b = pick_entry(1'b1, got_a, tag_a, tag_b);
			if (got_b && ($urandom % 4 != 0))
			begin
				cdb2_valid <= 1'b1;
				cdb2_tag   <= tag_b;
				cdb2_data  <= {$urandom, $urandom};
			end
			got_a = pick_entry(1'b0, 1'b0, '0, tag_a);
			rel1_valid <= got_a && ($urandom % 3 == 0);
			rel1_idx   <= tag_a;
			got_b = pick_entry(1'b0, got_a, tag_a, tag_b);
			rel2_valid <= got_b && ($urandom % 3 == 0);
			rel2_idx   <= tag_b;
			if ($urandom % 32 == 0)
			begin
				mispredict_valid     <= 1'b1;
				mispredict_free_list <= {$urandom, $urandom} & m_allocated;
			end
			inst1_opa_idx <= prf_idx_t'($urandom);
			inst1_opb_idx <= prf_idx_t'($urandom);
			inst2_opa_idx <= prf_idx_t'($urandom);
			inst2_opb_idx <= prf_idx_t'($urandom);
			retire_idx    <= prf_idx_t'($urandom);
		end
		repeat (2) request_cycle(1'b0, 1'b0);  // lets the last compare run
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

//--- sources.f
design/prf_pkg.sv
design/prf_alloc.sv
design/prf_release.sv
design/prf_entry_array.sv
design/prf_read.sv
design/prf_top.sv
verif/prf_clock_gen.sv
verif/prf_tb.sv
